//--- sim/frontEnd_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_defines.svh"

module frontEnd_tb import rvCorePkg::*; ();

	localparam int TEST_CYCLES = 700;		// Rough length of all tests together
	localparam int LIMIT = 4 * TEST_CYCLES;

	logic clk, nrst;
	logic [31:0] imemAdr, imemDat, redirectPc, issuePc, issueImm;
	logic imemCyc, imemStb, imemAck, redirectValid, retireValid, issueValid, issueReady;
	regIdxT retireRd, issueRs1, issueRs2, issueRd;
	aluFnT issueAluFn;
	fuSelT issueFu;
	memOpT issueMemOp;
	mulDivOpT issueMulDivOp;
	bSelT issueBSel;
	logic issueRegWe, issueBneq, issueBtype, issueJal, issueJalr, issueLui, issueAuipc;

	integer seed = 32'hd01f_0149;
	int cycles = 0;
	int errCount = 0;
	logic autoRetire, randomReady, pendRetire;		// Retire issued writers after take
	regIdxT pendRd;
	logic [31:0] prog [$];		// Program placed from address 0

	frontEnd i_frontEnd (.*);

	imemModel i_imem (
		.clk(clk), .nrst(nrst), .adr(imemAdr), .cyc(imemCyc), .stb(imemStb),
		.dat(imemDat), .ack(imemAck)
	);

	always #4 clk = !clk;

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > LIMIT)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
			$display("Something failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] encR(input logic [6:0] f7, input regIdxT rs2, rs1,
		input logic [2:0] f3, input regIdxT rd);
		return {f7, rs2, rs1, f3, rd, `OP_REG};
	endfunction

	function automatic logic [31:0] encI(input logic [31:0] imm, input regIdxT rs1,
		input logic [2:0] f3, input regIdxT rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [31:0] imm, input regIdxT rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
	endfunction

	function automatic logic [31:0] encB(input logic [31:0] imm, input regIdxT rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] encJ(input logic [31:0] imm, input regIdxT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	// ALU function by funct3, alt marks SUB or SRA
	function automatic aluFnT aluOf(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: aluOf = alt ? ALU_SUB : ALU_ADD;
			3'd1: aluOf = ALU_SLL;
			3'd2: aluOf = ALU_SLT;
			3'd3: aluOf = ALU_SLTU;
			3'd4: aluOf = ALU_XOR;
			3'd5: aluOf = alt ? ALU_SRA : ALU_SRL;
			3'd6: aluOf = ALU_OR;
			default: aluOf = ALU_AND;
		endcase
	endfunction

	// Reference decode straight from the RV32IM encodings
	function automatic decodedInstrT golden(input logic [31:0] pc, input logic [31:0] w);
		decodedInstrT e;
		logic [2:0] f3;
		f3 = w[14:12];
		e = '0;
		e.pc = pc;
		e.rs1 = w[19:15];
		e.rs2 = w[24:20];
		e.rd = w[11:7];
		e.imm = {{20{w[31]}}, w[31:20]};		// I format unless changed
		case (w[6:0])
			`OP_LUI, `OP_AUIPC:
			begin
				e.imm = {w[31:12], 12'h000};
				e.bSel = BSEL_IMM;
				e.regWe = 1'b1;
				e.lui = (w[6:0] == `OP_LUI);
				e.auipc = (w[6:0] == `OP_AUIPC);
			end
			`OP_JAL, `OP_JALR:
			begin
				if (w[6:0] == `OP_JAL)
					e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				e.fu = FU_BRANCH;
				e.bSel = BSEL_PC4;
				e.regWe = 1'b1;
				e.jal = (w[6:0] == `OP_JAL);
				e.jalr = (w[6:0] == `OP_JALR);
			end
			`OP_BRANCH:
			begin
				e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				e.fu = FU_BRANCH;
				e.btype = 1'b1;
				e.bneq = (f3 == 3'd1 || f3 == 3'd5 || f3 == 3'd7);		// BNE, BGE, BGEU
				e.aluFn = (f3 < 3'd4) ? ALU_SUB : ((f3 < 3'd6) ? ALU_SLT : ALU_SLTU);
			end
			`OP_LOAD, `OP_STORE:
			begin
				e.fu = FU_MEM;
				e.bSel = BSEL_IMM;
				e.regWe = (w[6:0] == `OP_LOAD);
				if (w[6:0] == `OP_STORE)
				begin
					e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
					e.memOp = (f3 == 3'd0) ? MEM_SB : ((f3 == 3'd1) ? MEM_SH : MEM_SW);
				end
				else
					e.memOp = (f3 == 3'd0) ? MEM_LB : (f3 == 3'd1) ? MEM_LH :
						(f3 == 3'd2) ? MEM_LW : (f3 == 3'd4) ? MEM_LBU : MEM_LHU;
			end
			`OP_IMM:
			begin
				e.bSel = BSEL_IMM;
				e.regWe = 1'b1;
				e.aluFn = aluOf(f3, f3 == 3'd5 && w[30]);
			end
			`OP_REG:
			begin
				e.regWe = 1'b1;
				if (w[31:25] == 7'd1)
				begin
					e.fu = FU_MULDIV;
					e.mulDivOp = f3;
				end
				else
					e.aluFn = aluOf(f3, w[30]);
			end
			default: e.fu = FU_ILLEGAL;		// Nothing written
		endcase
		return e;
	endfunction

	function automatic decodedInstrT issueBundle();
		return '{pc: issuePc, rs1: issueRs1, rs2: issueRs2, rd: issueRd, imm: issueImm,
			aluFn: issueAluFn, fu: issueFu, memOp: issueMemOp, mulDivOp: issueMulDivOp,
			bSel: issueBSel, regWe: issueRegWe, bneq: issueBneq, btype: issueBtype,
			jal: issueJal, jalr: issueJalr, lui: issueLui, auipc: issueAuipc};
	endfunction

	task automatic stopOnError();
		errCount++;
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compareField(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got)
		begin
			$display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			stopOnError();
		end
	endtask

	task automatic checkDecoded(input decodedInstrT exp, input decodedInstrT got);
		compareField("pc", exp.pc, got.pc);
		compareField("rs1", exp.rs1, got.rs1);
		compareField("rs2", exp.rs2, got.rs2);
		compareField("rd", exp.rd, got.rd);
		compareField("imm", exp.imm, got.imm);
		compareField("aluFn", exp.aluFn, got.aluFn);
		compareField("fu", exp.fu, got.fu);
		compareField("memOp", exp.memOp, got.memOp);
		compareField("mulDivOp", exp.mulDivOp, got.mulDivOp);
		compareField("bSel", exp.bSel, got.bSel);
		compareField("regWe", exp.regWe, got.regWe);
		compareField("bneq", exp.bneq, got.bneq);
		compareField("btype", exp.btype, got.btype);
		compareField("jal", exp.jal, got.jal);
		compareField("jalr", exp.jalr, got.jalr);
		compareField("lui", exp.lui, got.lui);
		compareField("auipc", exp.auipc, got.auipc);
	endtask

	task automatic checkPc(input logic [31:0] exp, input logic [31:0] got);
		compareField("issue PC", exp, got);
	endtask

	task automatic checkIdle();
		if (issueValid !== 1'b0)
		begin
			$display("FAIL at %0t ns: issue port active, PC %h", $time, issuePc);
			stopOnError();
		end
	endtask

	// Wishbone request lines move together, both low when idle
	task automatic checkBus(input logic expIdle);
		if (imemCyc !== imemStb || (expIdle && imemStb !== 1'b0))
		begin
			$display("FAIL at %0t ns: bus cyc %b stb %b", $time, imemCyc, imemStb);
			stopOnError();
		end
	endtask

	// Fill words are ADDI x0 with the word index as immediate, then the program
	task automatic startRun();
		nrst = 1'b0;
		redirectValid = 1'b0;
		redirectPc = '0;
		retireValid = 1'b0;
		retireRd = '0;
		issueReady = 1'b0;
		pendRetire = 1'b0;
		pendRd = '0;
		for (int i = 0; i < 256; i++)
			i_imem.mem[i] = encI(i, 5'd0, 3'd0, 5'd0, `OP_IMM);
		foreach (prog[i])
			i_imem.mem[i] = prog[i];
		repeat (16) @(negedge clk);
		checkIdle();		// Quiet ports in reset
		checkBus(1'b1);
		nrst = 1'b1;
	endtask

	// Waits for the next transfer, holding values checked while stalled
	task automatic takeInstr(output decodedInstrT got);
		decodedInstrT held;
		logic waiting, done;
		waiting = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			checkBus(1'b0);
			retireValid = pendRetire;
			retireRd = pendRd;
			pendRetire = 1'b0;
			issueReady = randomReady ? (({$random(seed)} % 3) != 0) : 1'b1;
			if (issueValid && waiting)
				checkDecoded(held, issueBundle());
			if (issueValid && issueReady)
			begin
				got = issueBundle();
				done = 1'b1;
				pendRetire = autoRetire && got.regWe;
				pendRd = got.rd;
			end
			else if (issueValid)
			begin
				held = issueBundle();
				waiting = 1'b1;
			end
		end
	endtask

	task automatic expectSeq(input logic [31:0] startPc, input int n);
		decodedInstrT got;
		logic [31:0] pc;
		for (int i = 0; i < n; i++)
		begin
			pc = startPc + 4 * i;
			takeInstr(got);
			checkPc(pc, got.pc);
			checkDecoded(golden(pc, i_imem.mem[pc[9:2]]), got);
		end
	endtask

	task automatic straightLine();
		prog = '{encI(5, 0, 0, 1, `OP_IMM), encI(-7, 0, 2, 2, `OP_IMM),
			encI(12'h0ff, 4, 4, 3, `OP_IMM), encR(7'h20, 5, 4, 0, 6), encR(0, 8, 7, 6, 9),
			encI(12'h403, 11, 5, 10, `OP_IMM), encR(0, 14, 13, 1, 12), encI(-1, 16, 7, 15, `OP_IMM)};
		startRun();
		expectSeq(`RESET_PC, 8);
	endtask

	task automatic instrMix();
		prog = '{encI(8, 2, 2, 1, `OP_LOAD), encI(-2, 3, 5, 20, `OP_LOAD), encS(-4, 3, 4, 0),
			encS(64, 5, 6, 2), encB(16, 6, 5, 0), encB(-8, 8, 7, 7), encB(-2048, 2, 3, 5),
			encJ(2048, 9), encI(12, 11, 0, 10, `OP_JALR), {20'habcde, 5'd12, `OP_LUI},
			{20'h00001, 5'd13, `OP_AUIPC}, encR(1, 16, 15, 0, 14), encR(1, 19, 18, 5, 17),
			32'h0000_007f};
		startRun();
		expectSeq(`RESET_PC, 14);
	endtask

	task automatic rawHazard();
		prog = '{encI(7, 0, 0, 0, `OP_IMM), encI(9, 0, 0, 0, `OP_IMM), encR(0, 0, 0, 0, 7),
			encI(1, 0, 0, 5, `OP_IMM), encR(0, 5, 5, 0, 6)};
		autoRetire = 1'b0;
		startRun();
		expectSeq(`RESET_PC, 4);		// x0 writers pass freely
		repeat (20)
		begin
			@(negedge clk);
			checkIdle();		// Reader of x5 held back
		end
		retireValid = 1'b1;
		retireRd = 5'd5;
		@(negedge clk);
		retireValid = 1'b0;
		expectSeq(`RESET_PC + 16, 1);
		autoRetire = 1'b1;
	endtask

	task automatic backPressure();
		prog = '{encI(3, 1, 0, 2, `OP_IMM), encR(0, 4, 3, 7, 5), encR(1, 7, 6, 4, 8)};
		randomReady = 1'b1;
		startRun();
		expectSeq(`RESET_PC, 20);
		randomReady = 1'b0;
	endtask

	task automatic redirect();
		prog.delete();
		startRun();
		expectSeq(`RESET_PC, 2);
		do
			@(negedge clk);
		while (!(imemStb && !imemAck));		// Bus cycle in flight
		redirectValid = 1'b1;
		redirectPc = 32'h0000_0100;
		@(negedge clk);
		redirectValid = 1'b0;
		expectSeq(32'h0000_0100, 4);
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		autoRetire = 1'b1;
		randomReady = 1'b0;
		redirectValid = 1'b0;
		redirectPc = '0;
		retireValid = 1'b0;
		retireRd = '0;
		issueReady = 1'b0;
		straightLine();
		instrMix();
		rawHazard();
		backPressure();
		redirect();
		if (errCount == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- sim/imemModel.sv
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic read-only memory, 256 words, 1 to 3 wait cycles
module imemModel (
	input  wire         clk,
	input  wire         nrst,
	input  wire  [31:0] adr,
	input  wire         cyc,
	input  wire         stb,
	output logic [31:0] dat,
	output logic        ack
);

	logic [31:0] mem [0:255];		// Written by the testbench
	integer      seed = 32'hd01f_0149;
	logic [1:0]  waitCnt;
	logic        pending;		// Request seen, ack not yet given

	assign dat = mem[adr[9:2]];		// Word address

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ack     <= 1'b0;
			pending <= 1'b0;
			waitCnt <= 2'd0;
		end
		else if (ack)
		begin
			ack     <= 1'b0;		// One-cycle ack, cycle ends
			pending <= 1'b0;
		end
		else if (cyc && stb)
		begin
			if (!pending)
			begin
				pending <= 1'b1;
				waitCnt <= {$random(seed)} % 3;		// Random extra wait
			end
			else if (waitCnt == 2'd0)
				ack <= 1'b1;
			else
				waitCnt <= waitCnt - 2'd1;
		end
	end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_defines.svh"

module decodeStage import rvCorePkg::*; (
	input  logic         clk,
	input  logic         nrst,
	input  logic         inValid,		// Decode register holds a word
	output logic         inReady,
	input  fetchPktT     inPkt,
	output logic         outValid,
	input  logic         outReady,
	output decodedInstrT outInstr,
	input  logic         retireValid,
	input  regIdxT       retireRd
);

	logic [31:0] instr;
	logic [31:0] imm;
	regIdxT      rs1, rs2, rd;
	fuSelT       fu;
	aluFnT       aluFn;
	memOpT       memOp;
	mulDivOpT    mulDivOp;
	bSelT        bSel;
	logic        regWe, bneq, btype, jal, jalr, lui, auipc;
	logic        usesRs1, usesRs2;
	logic        hazard;
	logic        issueFire;

	assign instr = inPkt.instr;
	assign rs1   = instr[19:15];
	assign rs2   = instr[24:20];
	assign rd    = instr[11:7];

	// One immediate, format by opcode, sign from bit 31
	always_comb
	begin
		case (instr[6:0])
			`OP_STORE:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			`OP_BRANCH:         imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			`OP_LUI, `OP_AUIPC: imm = {instr[31:12], 12'b0};
			`OP_JAL:            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default:            imm = {{20{instr[31]}}, instr[31:20]};		// I, R unused
		endcase
	end

	instrDecoder i_decoder (
		.instr(instr), .fu(fu), .aluFn(aluFn), .memOp(memOp), .mulDivOp(mulDivOp),
		.bSel(bSel), .regWe(regWe), .bneq(bneq), .btype(btype), .jal(jal), .jalr(jalr),
		.lui(lui), .auipc(auipc), .usesRs1(usesRs1), .usesRs2(usesRs2)
	);

	// Hold in place while a register is in flight
	assign outValid  = inValid && !hazard;
	assign inReady   = outReady && !hazard;
	assign issueFire = outValid && outReady;		// Handoff marks rd busy

	regScoreboard i_scoreboard (
		.clk(clk), .nrst(nrst),
		.issueFire(issueFire), .issueRd(rd), .issueWe(regWe),
		.retireValid(retireValid), .retireRd(retireRd),
		.rs1(rs1), .rs2(rs2), .rd(rd), .usesRs1(usesRs1), .usesRs2(usesRs2),
		.hazard(hazard)
	);

	assign outInstr = '{pc: inPkt.pc, rs1: rs1, rs2: rs2, rd: rd, imm: imm, aluFn: aluFn,
		fu: fu, memOp: memOp, mulDivOp: mulDivOp, bSel: bSel, regWe: regWe, bneq: bneq,
		btype: btype, jal: jal, jalr: jalr, lui: lui, auipc: auipc};

endmodule

`default_nettype wire

//--- src/fetchLink.sv
`timescale 1ns/100ps
`default_nettype none

// Fetch to decode-register handshake
interface fetchLink import rvCorePkg::*; ();

	logic     valid;		// Packet offered
	logic     ready;		// Pipe register can take it
	fetchPktT pkt;
	logic     kill;		// Redirect, empty the pipe

	modport source (
		output valid, pkt, kill,
		input  ready
	);

	modport sink (
		input  valid, pkt, kill,
		output ready
	);

endinterface

`default_nettype wire

//--- src/frontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module frontEnd import rvCorePkg::*; (
	input  logic        clk,
	input  logic        nrst,
	output logic [31:0] imemAdr,
	output logic        imemCyc,
	output logic        imemStb,
	input  logic [31:0] imemDat,
	input  logic        imemAck,
	input  logic        redirectValid,
	input  logic [31:0] redirectPc,
	input  logic        retireValid,
	input  regIdxT      retireRd,
	output logic        issueValid,
	input  logic        issueReady,
	output logic [31:0] issuePc,
	output regIdxT      issueRs1,
	output regIdxT      issueRs2,
	output regIdxT      issueRd,
	output logic [31:0] issueImm,
	output aluFnT       issueAluFn,
	output fuSelT       issueFu,
	output memOpT       issueMemOp,
	output mulDivOpT    issueMulDivOp,
	output bSelT        issueBSel,
	output logic        issueRegWe,
	output logic        issueBneq,
	output logic        issueBtype,
	output logic        issueJal,
	output logic        issueJalr,
	output logic        issueLui,
	output logic        issueAuipc
);

	fetchLink     link ();
	fetchPktT     decPkt;		// Decode register contents
	logic         decValid, decReady;
	decodedInstrT handInstr;		// Decoded, not yet registered
	logic         handValid, handReady;
	decodedInstrT issueInstr;

	instrFetch i_fetch (
		.clk(clk), .nrst(nrst), .redirectValid(redirectValid), .redirectPc(redirectPc),
		.imemAdr(imemAdr), .imemCyc(imemCyc), .imemStb(imemStb),
		.imemDat(imemDat), .imemAck(imemAck), .link(link.source)
	);

	pipeStage #(.payloadT(fetchPktT)) i_fetchPipe (
		.clk(clk), .nrst(nrst), .flush(link.kill),
		.inValid(link.valid), .inReady(link.ready), .inData(link.pkt),
		.outValid(decValid), .outReady(decReady), .outData(decPkt)
	);

	decodeStage i_decode (
		.clk(clk), .nrst(nrst), .inValid(decValid), .inReady(decReady), .inPkt(decPkt),
		.outValid(handValid), .outReady(handReady), .outInstr(handInstr),
		.retireValid(retireValid), .retireRd(retireRd)
	);

	pipeStage #(.payloadT(decodedInstrT)) i_issuePipe (
		.clk(clk), .nrst(nrst), .flush(link.kill),
		.inValid(handValid), .inReady(handReady), .inData(handInstr),
		.outValid(issueValid), .outReady(issueReady), .outData(issueInstr)
	);

	// Bundle split onto flat issue ports
	assign issuePc       = issueInstr.pc;
	assign issueRs1      = issueInstr.rs1;
	assign issueRs2      = issueInstr.rs2;
	assign issueRd       = issueInstr.rd;
	assign issueImm      = issueInstr.imm;
	assign issueAluFn    = issueInstr.aluFn;
	assign issueFu       = issueInstr.fu;
	assign issueMemOp    = issueInstr.memOp;
	assign issueMulDivOp = issueInstr.mulDivOp;
	assign issueBSel     = issueInstr.bSel;
	assign issueRegWe    = issueInstr.regWe;
	assign issueBneq     = issueInstr.bneq;
	assign issueBtype    = issueInstr.btype;
	assign issueJal      = issueInstr.jal;
	assign issueJalr     = issueInstr.jalr;
	assign issueLui      = issueInstr.lui;
	assign issueAuipc    = issueInstr.auipc;

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_defines.svh"

module instrDecoder import rvCorePkg::*; (
	input  logic [31:0] instr,
	output fuSelT       fu,
	output aluFnT       aluFn,
	output memOpT       memOp,
	output mulDivOpT    mulDivOp,
	output bSelT        bSel,
	output logic        regWe,
	output logic        bneq,
	output logic        btype,
	output logic        jal,
	output logic        jalr,
	output logic        lui,
	output logic        auipc,
	output logic        usesRs1,
	output logic        usesRs2
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Shared funct3 map of OP and OP-IMM, alt picks SUB or SRA
	function automatic aluFnT aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb
	begin
		fu = FU_ALU;
		aluFn = ALU_ADD;
		memOp = MEM_NONE;
		mulDivOp = 3'b000;
		bSel = BSEL_REG;
		{regWe, bneq, btype, jal, jalr, lui, auipc} = '0;
		{usesRs1, usesRs2, illegal} = '0;
		case (opcode)
			`OP_LUI:   {bSel, regWe, lui} = {BSEL_IMM, 2'b11};
			`OP_AUIPC: {bSel, regWe, auipc} = {BSEL_IMM, 2'b11};
			`OP_JAL:   {fu, bSel, regWe, jal} = {FU_BRANCH, BSEL_PC4, 2'b11};		// Link rd=pc+4
			`OP_JALR:
			begin
				illegal = (funct3 != 3'b000);
				{fu, bSel, regWe, jalr, usesRs1} = {FU_BRANCH, BSEL_PC4, 3'b111};
			end
			`OP_BRANCH:
			begin
				illegal = (funct3[2:1] == 2'b01);		// 010, 011 unused
				{fu, btype, usesRs1, usesRs2} = {FU_BRANCH, 3'b111};
				bneq = funct3[0];		// BNE, BGE, BGEU invert
				aluFn = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
			end
			`OP_LOAD:
			begin
				{fu, bSel, regWe, usesRs1} = {FU_MEM, BSEL_IMM, 2'b11};
				case (funct3)
					3'b000:  memOp = MEM_LB;
					3'b001:  memOp = MEM_LH;
					3'b010:  memOp = MEM_LW;
					3'b100:  memOp = MEM_LBU;
					3'b101:  memOp = MEM_LHU;
					default: illegal = 1'b1;
				endcase
			end
			`OP_STORE:
			begin
				{fu, bSel, usesRs1, usesRs2} = {FU_MEM, BSEL_IMM, 2'b11};		// Address from imm
				case (funct3)
					3'b000:  memOp = MEM_SB;
					3'b001:  memOp = MEM_SH;
					3'b010:  memOp = MEM_SW;
					default: illegal = 1'b1;
				endcase
			end
			`OP_IMM:
			begin
				{bSel, regWe, usesRs1} = {BSEL_IMM, 2'b11};
				aluFn = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					illegal = 1'b1;
				if (funct3 == 3'b101 && {funct7[6], funct7[4:0]} != 6'b000000)
					illegal = 1'b1;		// Only SRLI, SRAI
			end
			`OP_REG:
			begin
				{regWe, usesRs1, usesRs2} = 3'b111;
				if (funct7 == 7'b0000001)
				begin
					fu = FU_MULDIV;
					mulDivOp = funct3;
				end
				else
					aluFn = aluFromFunct3(funct3, funct7[5]);
				if (funct7 == 7'b0100000 && funct3 != 3'b000 && funct3 != 3'b101)
					illegal = 1'b1;
				else if (funct7 != 7'b0000000 && funct7 != 7'b0100000 && funct7 != 7'b0000001)
					illegal = 1'b1;
			end
			default: illegal = 1'b1;		// Also SYSTEM, FENCE, compressed
		endcase
		// Illegal word reads and writes nothing
		if (illegal)
		begin
			fu = FU_ILLEGAL;
			aluFn = ALU_ADD;
			memOp = MEM_NONE;
			mulDivOp = 3'b000;
			bSel = BSEL_REG;
			{regWe, bneq, btype, jal, jalr, lui, auipc} = '0;
			{usesRs1, usesRs2} = 2'b00;
		end
	end

endmodule

`default_nettype wire

//--- src/instrFetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_defines.svh"

module instrFetch (
	input  logic        clk,
	input  logic        nrst,
	input  logic        redirectValid,
	input  logic [31:0] redirectPc,
	output logic [31:0] imemAdr,
	output logic        imemCyc,
	output logic        imemStb,
	input  logic [31:0] imemDat,
	input  logic        imemAck,
	fetchLink.source    link
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_HOLD} fetchStateT;

	fetchStateT  state;
	logic [31:0] pc;		// Address of the word on the bus or held
	logic [31:0] redirPc;		// Target saved while an old cycle drains
	logic        drop;		// Data of the running cycle is stale
	logic [31:0] instrHold;
	logic        pktValid;

	assign imemAdr = pc;
	assign imemCyc = (state == S_REQ);
	assign imemStb = (state == S_REQ);

	// Offered in the ack cycle, or later from the hold register
	assign pktValid = ((state == S_REQ && imemAck && !drop) || state == S_HOLD) && !redirectValid;

	assign link.valid = pktValid;
	assign link.kill  = redirectValid;
	assign link.pkt   = '{pc: pc, instr: (state == S_HOLD) ? instrHold : imemDat};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= S_IDLE;
			pc    <= `RESET_PC;
			drop  <= 1'b0;
		end
		else if (redirectValid)
		begin
			if (state == S_REQ && !imemAck)
				drop <= 1'b1;		// Let the bus cycle finish, keep address
			else
			begin
				pc    <= redirectPc;
				state <= S_REQ;
				drop  <= 1'b0;
			end
		end
		else
		begin
			case (state)
				S_IDLE: state <= S_REQ;		// First strobe after reset
				S_REQ:
				begin
					if (imemAck)
					begin
						if (drop)
						begin
							pc   <= redirPc;		// Restart on new path
							drop <= 1'b0;
						end
						else if (link.ready)
							pc <= pc + 32'd4;
						else
							state <= S_HOLD;		// Decode full, park the word
					end
				end
				S_HOLD:
				begin
					if (link.ready)
					begin
						pc    <= pc + 32'd4;
						state <= S_REQ;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_REQ && imemAck && !link.ready)
			instrHold <= imemDat;
		if (redirectValid)
			redirPc <= redirectPc;
	end

	// Slave acks only a request still on the bus
	aAckInCyc: assert property (@(posedge clk) disable iff (!nrst)
		imemAck |-> imemCyc && imemStb);
	// Classic handshake, request held steady until ack
	aAdrHold: assert property (@(posedge clk) disable iff (!nrst)
		imemStb && !imemAck |=> imemStb && $stable(imemAdr));

endmodule

`default_nettype wire

//--- src/pipeStage.sv
`timescale 1ns/100ps
`default_nettype none

// One-entry register slice, ready passes through when draining
module pipeStage #(
	parameter type payloadT = logic [31:0]
) (
	input  logic    clk,
	input  logic    nrst,
	input  logic    flush,		// Drop the entry on this edge
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);

	assign inReady = (!outValid || outReady) && !flush;		// Empty or being taken, none on flush

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			outValid <= 1'b0;
		else if (flush)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
			outData <= inData;
	end

	// Stalled output holds its value
	aHold: assert property (@(posedge clk) disable iff (!nrst)
		outValid && !outReady && !flush |=> outValid && $stable(outData));

endmodule

`default_nettype wire

//--- src/regScoreboard.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_defines.svh"

module regScoreboard import rvCorePkg::*; (
	input  logic   clk,
	input  logic   nrst,
	input  logic   issueFire,
	input  regIdxT issueRd,
	input  logic   issueWe,
	input  logic   retireValid,
	input  regIdxT retireRd,
	input  regIdxT rs1,
	input  regIdxT rs2,
	input  regIdxT rd,
	input  logic   usesRs1,
	input  logic   usesRs2,
	output logic   hazard
);

	logic [`NUM_REGS-1:0] busy;		// Write pending per register
	logic [`NUM_REGS-1:0] setMask;
	logic [`NUM_REGS-1:0] clrMask;

	always_comb
	begin
		setMask = '0;
		clrMask = '0;
		if (issueFire && issueWe && issueRd != 5'd0)
			setMask[issueRd] = 1'b1;		// x0 never tracked
		if (retireValid)
			clrMask[retireRd] = 1'b1;
	end

	// Set wins over a same-cycle retire
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			busy <= '0;
		else
			busy <= (busy & ~clrMask) | setMask;
	end

	// RAW on sources, WAW on destination
	assign hazard = (usesRs1 && busy[rs1]) || (usesRs2 && busy[rs2]) || (issueWe && busy[rd]);

	aX0Free: assert property (@(posedge clk) disable iff (!nrst) !busy[0]);
	// Decode gating never lets a second writer of a busy register through
	aNoWaw: assert property (@(posedge clk) disable iff (!nrst)
		issueFire && issueWe |-> !busy[issueRd]);

endmodule

`default_nettype wire

//--- src/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

	typedef logic [4:0] regIdxT;		// x0..x31

	// PC and raw word from fetch
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetchPktT;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} aluFnT;

	// Target functional unit
	typedef enum logic [2:0] {
		FU_ALU     = 3'd0,
		FU_BRANCH  = 3'd1,
		FU_MEM     = 3'd2,
		FU_MULDIV  = 3'd3,
		FU_ILLEGAL = 3'd4
	} fuSelT;

	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} memOpT;

	typedef logic [2:0] mulDivOpT;		// funct3 of an M-extension op

	// Operand B source
	typedef enum logic [1:0] {
		BSEL_REG = 2'd0,
		BSEL_IMM = 2'd1,
		BSEL_PC4 = 2'd2
	} bSelT;

	// Control bundle handed to issue, 102 bits
	typedef struct packed {
		logic [31:0] pc;
		regIdxT      rs1;
		regIdxT      rs2;
		regIdxT      rd;
		logic [31:0] imm;
		aluFnT       aluFn;
		fuSelT       fu;
		memOpT       memOp;
		mulDivOpT    mulDivOp;
		bSelT        bSel;
		logic        regWe;
		logic        bneq;		// Invert compare result
		logic        btype;		// Conditional branch
		logic        jal;
		logic        jalr;
		logic        lui;
		logic        auipc;
	} decodedInstrT;

endpackage

`default_nettype wire

//--- src/rvCore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Architectural integer registers
`define NUM_REGS 32

// RV32 major opcodes, instr[6:0]
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

`endif

//--- vlog.f
+incdir+src
src/rvCorePkg.sv
src/fetchLink.sv
src/instrFetch.sv
src/pipeStage.sv
src/instrDecoder.sv
src/regScoreboard.sv
src/decodeStage.sv
src/frontEnd.sv
sim/imemModel.sv
sim/frontEnd_tb.sv
